//--- rtl/isa_pkg.sv
// Operation encodings shared by the execute and memory stages
// Decode drives these codes, exu_alu, exu_bru and lsu interpret them
`default_nettype none

package isa_pkg;

  localparam int XLEN          = 32;
  localparam int AluOpWidth    = 4;
  localparam int BranchOpWidth = 3;
  localparam int LsuOpWidth    = 3;

  // Register/immediate ALU operations, passb serves LUI
  typedef enum logic [AluOpWidth-1:0] {
    alu_add   = 4'd0,
    alu_sub   = 4'd1,
    alu_sll   = 4'd2,
    alu_slt   = 4'd3,
    alu_sltu  = 4'd4,
    alu_xor   = 4'd5,
    alu_srl   = 4'd6,
    alu_sra   = 4'd7,
    alu_or    = 4'd8,
    alu_and   = 4'd9,
    alu_passb = 4'd10
  } alu_op_e;

  typedef enum logic [BranchOpWidth-1:0] {
    br_beq  = 3'd0,
    br_bne  = 3'd1,
    br_blt  = 3'd2,
    br_bge  = 3'd3,
    br_bltu = 3'd4,
    br_bgeu = 3'd5
  } br_op_e;

  // Loads occupy the low codes, stores the top three
  typedef enum logic [LsuOpWidth-1:0] {
    lsu_lb  = 3'd0,
    lsu_lh  = 3'd1,
    lsu_lw  = 3'd2,
    lsu_lbu = 3'd3,
    lsu_lhu = 3'd4,
    lsu_sb  = 3'd5,
    lsu_sh  = 3'd6,
    lsu_sw  = 3'd7
  } lsu_op_e;

endpackage : isa_pkg

`default_nettype wire

//--- rtl/pipe_pkg.sv
// Payload that the execute stage hands to the memory stage
// Carried by ex_mem_if, loaded into the exu output register
`default_nettype none

package pipe_pkg;

  typedef struct packed {
    logic [31:0]      alu_res;     // ALU result, load/store address or redirect target
    logic [31:0]      store_data;  // Unshifted rs2 value for stores
    isa_pkg::lsu_op_e lsu_op;
    logic             lsu;         // Item needs a Wishbone access
    logic [4:0]       rd_addr;
    logic             rd_en;
    logic             compressed;
  } ex_mem_t;

  // Value of the execute/memory register out of reset
  localparam ex_mem_t EX_MEM_RESET = '0;

endpackage : pipe_pkg

`default_nettype wire

//--- rtl/ex_mem_if.sv
// Execute-to-memory link with valid and back-pressure stall
// exu connects as producer, lsu as consumer
`default_nettype none

interface ex_mem_if;
  import pipe_pkg::*;

  logic    valid;
  ex_mem_t payload;
  logic    stall;  // Memory stage cannot take a new item

  modport producer (
    output valid,
    output payload,
    input  stall
  );

  modport consumer (
    input  valid,
    input  payload,
    output stall
  );

endinterface : ex_mem_if

`default_nettype wire

//--- rtl/exu_alu.sv
// Combinational RV32I integer ALU
// Operand selection happens in exu, this block only computes
`default_nettype none

module exu_alu (
  input  logic [isa_pkg::XLEN-1:0] a,
  input  logic [isa_pkg::XLEN-1:0] b,
  input  isa_pkg::alu_op_e         alu_op,
  output logic [isa_pkg::XLEN-1:0] res
);
  import isa_pkg::*;

  logic [4:0] shamt;

  assign shamt = b[4:0];  // RV32 shifts only look at five bits

  always_comb begin
    case (alu_op)
      alu_add:   res = a + b;
      alu_sub:   res = a - b;
      alu_sll:   res = a << shamt;
      alu_slt:   res = {{(XLEN-1){1'b0}}, $signed(a) < $signed(b)};
      alu_sltu:  res = {{(XLEN-1){1'b0}}, a < b};
      alu_xor:   res = a ^ b;
      alu_srl:   res = a >> shamt;
      alu_sra:   res = $unsigned($signed(a) >>> shamt);
      alu_or:    res = a | b;
      alu_and:   res = a & b;
      alu_passb: res = b;
      default:   res = '0;
    endcase
  end

endmodule : exu_alu

`default_nettype wire

//--- rtl/exu_bru.sv
// Branch condition evaluation for the six RV32I compare types
`default_nettype none

module exu_bru (
  input  logic                     en,
  input  isa_pkg::br_op_e          br_type,
  input  logic [isa_pkg::XLEN-1:0] a,
  input  logic [isa_pkg::XLEN-1:0] b,
  output logic                     out
);
  import isa_pkg::*;

  logic cond;

  always_comb begin
    case (br_type)
      br_beq:  cond = (a == b);
      br_bne:  cond = (a != b);
      br_blt:  cond = ($signed(a) < $signed(b));
      br_bge:  cond = ($signed(a) >= $signed(b));
      br_bltu: cond = (a < b);
      br_bgeu: cond = (a >= b);
      default: cond = 1'b0;
    endcase
  end

  assign out = en && cond;  // Non-branches never report taken

endmodule : exu_bru

`default_nettype wire

//--- rtl/exu.sv
// Execute stage: operand select, ALU, branch resolution against the prediction
// and the stallable register that feeds the memory stage
`default_nettype none

module exu (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_e,
  input  logic [isa_pkg::XLEN-1:0] rs1_data_e,
  input  logic [isa_pkg::XLEN-1:0] rs2_data_e,
  input  logic [31:1]              pc_e,
  input  logic [isa_pkg::XLEN-1:0] imm_e,
  input  logic                     compressed_e,
  input  logic                     use_imm_e,
  input  logic                     use_pc_e,
  input  logic                     alu_e,
  input  isa_pkg::alu_op_e         alu_op_e,
  input  logic                     br_e,
  input  isa_pkg::br_op_e          br_op_e,
  input  logic                     br_taken_e,
  input  logic                     lsu_e,
  input  isa_pkg::lsu_op_e         lsu_op_e,
  input  logic [4:0]               rd_addr_e,
  input  logic                     rd_en_e,
  input  logic                     illegal_e,
  output logic                     should_br,
  output logic [isa_pkg::XLEN-1:0] redirect_pc,
  output logic                     br_mispredict,
  ex_mem_if.producer               mem
);
  import isa_pkg::*;
  import pipe_pkg::*;

  logic [XLEN-1:0]  pc_full;
  logic [XLEN-1:0]  op_a;
  logic [XLEN-1:0]  op_b;
  logic [XLEN-1:0]  alu_out;
  logic [XLEN-1:0]  res_next;
  logic             bru_out;
  logic             accept;
  logic             mispredict_raw;
  isa_pkg::alu_op_e alu_op_sel;
  ex_mem_t          payload_next;

  assign pc_full = {pc_e, 1'b0};
  assign op_a    = use_pc_e ? pc_full : rs1_data_e;
  assign op_b    = use_imm_e ? imm_e : rs2_data_e;
  assign accept  = valid_e && !mem.stall;

  // Loads, stores, branches and jumps only need an address sum
  always_comb begin
    if (alu_e) alu_op_sel = alu_op_e;
    else alu_op_sel = alu_add;
  end

  exu_alu u_alu (
    .a     (op_a),
    .b     (op_b),
    .alu_op(alu_op_sel),
    .res   (alu_out)
  );

  // Branch compare always uses the register operands
  exu_bru u_bru (
    .en     (br_e),
    .br_type(br_op_e),
    .a      (rs1_data_e),
    .b      (rs2_data_e),
    .out    (bru_out)
  );

  assign mispredict_raw = br_taken_e && !bru_out;
  assign br_mispredict  = accept && mispredict_raw;

  always_comb begin
    if (mispredict_raw) res_next = compressed_e ? pc_full + 32'd2 : pc_full + 32'd4;
    else res_next = alu_out;
  end

  always_comb begin
    payload_next            = EX_MEM_RESET;
    payload_next.alu_res    = res_next;
    payload_next.store_data = rs2_data_e;
    payload_next.lsu_op     = lsu_op_e;
    payload_next.lsu        = valid_e && lsu_e && !illegal_e;
    payload_next.rd_addr    = rd_addr_e;
    payload_next.rd_en      = valid_e && rd_en_e && !illegal_e;
    payload_next.compressed = compressed_e;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      should_br   <= 1'b0;
      mem.valid   <= 1'b0;
      mem.payload <= EX_MEM_RESET;
    end else begin
      should_br <= accept && !br_taken_e && bru_out;  // One pulse per taken, unpredicted branch
      if (!mem.stall) begin
        mem.valid   <= valid_e;
        mem.payload <= payload_next;
      end
    end
  end

  assign redirect_pc = mem.payload.alu_res;

endmodule : exu

`default_nettype wire

//--- rtl/lsu.sv
// Memory stage: Wishbone classic master for loads and stores plus the writeback register
// Non-memory items go straight to writeback, memory items hold the stage until ack
`default_nettype none

module lsu (
  input  logic                     clk,
  input  logic                     rst_n,
  ex_mem_if.consumer               mem,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [31:2]              wb_adr,
  output logic [3:0]               wb_sel,
  output logic [isa_pkg::XLEN-1:0] wb_dat_w,
  input  logic [isa_pkg::XLEN-1:0] wb_dat_r,
  input  logic                     wb_ack,
  output logic                     rd_en_w,
  output logic [4:0]               rd_addr_w,
  output logic [isa_pkg::XLEN-1:0] rd_data_w
);
  import isa_pkg::*;
  import pipe_pkg::*;

  typedef enum logic {
    s_idle,
    s_busy
  } state_t;

  state_t          state;
  ex_mem_t         item;
  logic            busy;
  logic            take;
  logic            done;
  logic            is_store;
  logic [1:0]      off;
  logic [XLEN-1:0] lane_data;
  logic [XLEN-1:0] load_data;

  assign busy      = (state == s_busy);
  assign mem.stall = busy;
  assign take      = mem.valid && !mem.stall;
  assign done      = busy && wb_ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= s_idle;
    end else if (take && mem.payload.lsu) begin
      state <= s_busy;
    end else if (done) begin
      state <= s_idle;  // cyc and stb fall on the edge after ack
    end
  end

  always_ff @(posedge clk) begin
    if (take) item <= mem.payload;
  end

  assign off      = item.alu_res[1:0];
  assign is_store = item.lsu_op inside {lsu_sb, lsu_sh, lsu_sw};

  assign wb_cyc   = busy;
  assign wb_stb   = busy;
  assign wb_we    = busy && is_store;
  assign wb_adr   = item.alu_res[31:2];
  assign wb_dat_w = item.store_data << {off, 3'b000};  // Move the store into its byte lanes

  always_comb begin
    case (item.lsu_op)
      lsu_lb, lsu_lbu, lsu_sb: wb_sel = 4'b0001 << off;
      lsu_lh, lsu_lhu, lsu_sh: wb_sel = 4'b0011 << off;
      default:                 wb_sel = 4'b1111;
    endcase
  end

  assign lane_data = wb_dat_r >> {off, 3'b000};

  always_comb begin
    case (item.lsu_op)
      lsu_lb:  load_data = {{24{lane_data[7]}}, lane_data[7:0]};
      lsu_lbu: load_data = {24'd0, lane_data[7:0]};
      lsu_lh:  load_data = {{16{lane_data[15]}}, lane_data[15:0]};
      lsu_lhu: load_data = {16'd0, lane_data[15:0]};
      default: load_data = lane_data;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_en_w <= 1'b0;
    end else if (take && !mem.payload.lsu) begin
      rd_en_w <= mem.payload.rd_en;
    end else if (done) begin
      rd_en_w <= item.rd_en && !is_store;  // Stores never write back
    end else begin
      rd_en_w <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take && !mem.payload.lsu) begin
      rd_addr_w <= mem.payload.rd_addr;
      rd_data_w <= mem.payload.alu_res;
    end else if (done) begin
      rd_addr_w <= item.rd_addr;
      rd_data_w <= load_data;
    end
  end

endmodule : lsu

`default_nettype wire

//--- rtl/exec_mem_top.sv
// Execute and memory stages joined by the execute-to-memory link
// Decode-side inputs, writeback, redirect and Wishbone master leave as plain ports
`default_nettype none

module exec_mem_top (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     valid_e,
  input  logic [isa_pkg::XLEN-1:0] rs1_data_e,
  input  logic [isa_pkg::XLEN-1:0] rs2_data_e,
  input  logic [31:1]              pc_e,
  input  logic [isa_pkg::XLEN-1:0] imm_e,
  input  logic                     compressed_e,
  input  logic                     use_imm_e,
  input  logic                     use_pc_e,
  input  logic                     alu_e,
  input  isa_pkg::alu_op_e         alu_op_e,
  input  logic                     br_e,
  input  isa_pkg::br_op_e          br_op_e,
  input  logic                     br_taken_e,
  input  logic                     lsu_e,
  input  isa_pkg::lsu_op_e         lsu_op_e,
  input  logic [4:0]               rd_addr_e,
  input  logic                     rd_en_e,
  input  logic                     illegal_e,
  output logic                     stall,
  output logic                     br_mispredict,
  output logic                     should_br,
  output logic [isa_pkg::XLEN-1:0] redirect_pc,
  output logic                     rd_en_w,
  output logic [4:0]               rd_addr_w,
  output logic [isa_pkg::XLEN-1:0] rd_data_w,
  output logic                     wb_cyc,
  output logic                     wb_stb,
  output logic                     wb_we,
  output logic [31:2]              wb_adr,
  output logic [3:0]               wb_sel,
  output logic [isa_pkg::XLEN-1:0] wb_dat_w,
  input  logic [isa_pkg::XLEN-1:0] wb_dat_r,
  input  logic                     wb_ack
);

  ex_mem_if ex_mem ();

  assign stall = ex_mem.stall;  // Upstream holds its instruction while lsu is busy

  exu u_exu (
    .clk          (clk),
    .rst_n        (rst_n),
    .valid_e      (valid_e),
    .rs1_data_e   (rs1_data_e),
    .rs2_data_e   (rs2_data_e),
    .pc_e         (pc_e),
    .imm_e        (imm_e),
    .compressed_e (compressed_e),
    .use_imm_e    (use_imm_e),
    .use_pc_e     (use_pc_e),
    .alu_e        (alu_e),
    .alu_op_e     (alu_op_e),
    .br_e         (br_e),
    .br_op_e      (br_op_e),
    .br_taken_e   (br_taken_e),
    .lsu_e        (lsu_e),
    .lsu_op_e     (lsu_op_e),
    .rd_addr_e    (rd_addr_e),
    .rd_en_e      (rd_en_e),
    .illegal_e    (illegal_e),
    .should_br    (should_br),
    .redirect_pc  (redirect_pc),
    .br_mispredict(br_mispredict),
    .mem          (ex_mem.producer)
  );

  lsu u_lsu (
    .clk      (clk),
    .rst_n    (rst_n),
    .mem      (ex_mem.consumer),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_sel   (wb_sel),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .rd_en_w  (rd_en_w),
    .rd_addr_w(rd_addr_w),
    .rd_data_w(rd_data_w)
  );

endmodule : exec_mem_top

`default_nettype wire

//--- bench/exec_mem_checker.sv
// Watches exec_mem_top and compares writeback, branch outputs and Wishbone stores
// The testbench feeds the expected values with each instruction it presents
`default_nettype none

module exec_mem_checker (
  input logic                  clk,
  input logic                  rst_n,
  input logic                  valid_e,
  input logic                  stall,
  input logic [31:0]           rs1_data_e,
  input logic [31:0]           rs2_data_e,
  input logic [31:0]           imm_e,
  input logic                  lsu_e,
  input isa_pkg::lsu_op_e      lsu_op_e,
  input logic [4:0]            rd_addr_e,
  input logic                  rd_en_e,
  input logic                  illegal_e,
  input logic [95:0]           test_name,
  input logic [31:0]           exp_wb,
  input logic [31:0]           exp_pc,
  input logic                  exp_sb,
  input logic                  exp_mp,
  input logic                  br_mispredict,
  input logic                  should_br,
  input logic [31:0]           redirect_pc,
  input logic                  rd_en_w,
  input logic [4:0]            rd_addr_w,
  input logic [31:0]           rd_data_w,
  input logic                  wb_cyc,
  input logic                  wb_stb,
  input logic                  wb_we,
  input logic [31:2]           wb_adr,
  input logic [3:0]            wb_sel,
  input logic [31:0]           wb_dat_w,
  input logic                  wb_ack
);
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;

  typedef struct packed {
    logic [95:0] name;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_exp_t;

  typedef struct packed {
    logic [95:0] name;
    logic [31:0] adr;
    logic [3:0]  sel;
    logic [31:0] data;
  } st_exp_t;

  wb_exp_t     wb_q[$];  // Writebacks in program order
  st_exp_t     st_q[$];
  int          value_errors = 0;
  int          other_errors = 0;
  logic        accept;
  logic        seen_accept;
  logic        sb_prev;
  logic        pc_prev_chk;
  logic [31:0] pc_prev;
  logic [95:0] name_prev;
  logic [31:0] addr;
  logic [1:0]  off;
  logic [3:0]  sel;
  wb_exp_t     w;
  st_exp_t     s;

  function automatic int pending();
    return wb_q.size() + st_q.size();
  endfunction

  function automatic logic [31:0] lane_mask(input logic [3:0] lanes);
    return {{8{lanes[3]}}, {8{lanes[2]}}, {8{lanes[1]}}, {8{lanes[0]}}};
  endfunction

  task automatic value_check(input logic [95:0] name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      value_errors++;
      $display("FAILED %s %s: expected %h, actual %h", name, what, exp, act);
    end
  endtask

  // Sampled on the falling edge, halfway between the edges that move data
  always @(negedge clk) begin
    if (!rst_n) begin
      seen_accept = 1'b0;
      sb_prev     = 1'b0;
      pc_prev_chk = 1'b0;
      name_prev   = '0;
    end else begin
      accept = valid_e && !stall;
      if (!seen_accept && (stall || should_br || rd_en_w || wb_cyc || wb_stb || wb_we)) begin
        other_errors++;
        $display("Control output went high after reset before any instruction was accepted");
      end
      value_check(test_name, "br_mispredict", accept && exp_mp, br_mispredict);
      value_check(name_prev, "should_br", sb_prev, should_br);
      if (pc_prev_chk) value_check(name_prev, "redirect_pc", pc_prev, redirect_pc);
      if (rd_en_w) begin
        if (wb_q.size() == 0) begin
          other_errors++;
          $display("Writeback to x%0d while no instruction was waiting for one", rd_addr_w);
        end else begin
          w = wb_q.pop_front();
          value_check(w.name, "rd_addr_w", w.rd, rd_addr_w);
          value_check(w.name, "rd_data_w", w.data, rd_data_w);
        end
      end
      if (wb_cyc && wb_stb && wb_we && wb_ack) begin
        if (st_q.size() == 0) begin
          other_errors++;
          $display("Wishbone write acknowledged while no store was pending");
        end else begin
          s = st_q.pop_front();
          value_check(s.name, "wb_adr", {s.adr[31:2], 2'b00}, {wb_adr, 2'b00});
          value_check(s.name, "wb_sel", s.sel, wb_sel);
          value_check(s.name, "wb_dat_w", s.data & lane_mask(s.sel),
                      wb_dat_w & lane_mask(s.sel));
        end
      end
      sb_prev     = accept && exp_sb;  // Registered outputs show up one cycle later
      pc_prev_chk = accept && (exp_sb || exp_mp);
      pc_prev     = exp_pc;
      name_prev   = test_name;
      if (accept) begin
        seen_accept = 1'b1;
        if (rd_en_e && !illegal_e) wb_q.push_back({test_name, rd_addr_e, exp_wb});
        if (lsu_e && !illegal_e &&
            (lsu_op_e == lsu_sb || lsu_op_e == lsu_sh || lsu_op_e == lsu_sw)) begin
          addr = rs1_data_e + imm_e;
          off  = addr[1:0];
          sel  = (lsu_op_e == lsu_sb) ? 4'b0001 : (lsu_op_e == lsu_sh) ? 4'b0011 : 4'b1111;
          st_q.push_back({test_name, addr, sel << off, rs2_data_e << (8 * off)});
        end
      end
    end
  end

endmodule : exec_mem_checker

`default_nettype wire

//--- bench/tb_exec_mem.sv
// Testbench for exec_mem_top: plays decode from a table and answers Wishbone from a
// 64-word memory with random ack delays, exec_mem_checker compares the results
`default_nettype none

module tb_exec_mem;
  timeunit 1ns;
  timeprecision 100ps;
  import isa_pkg::*;

  localparam int NumTests = 29;

  typedef struct packed {
    logic [95:0]      name;
    logic [31:0]      rs1;
    logic [31:0]      rs2;
    logic [31:0]      imm;
    logic [31:0]      pc;
    logic             use_imm;
    logic             use_pc;
    logic             compressed;
    logic             alu;
    logic             br;
    logic             taken;
    logic             lsu;
    logic             rd_en;
    logic             illegal;
    isa_pkg::alu_op_e alu_op;
    isa_pkg::br_op_e  br_op;
    isa_pkg::lsu_op_e lsu_op;
    logic [4:0]       rd;
    logic [31:0]      exp_wb;
    logic [31:0]      exp_pc;
    logic             exp_sb;
    logic             exp_mp;
  } entry_t;

  logic             clk;
  logic             rst_n;
  logic             valid_e;
  logic [31:0]      rs1_data_e;
  logic [31:0]      rs2_data_e;
  logic [31:1]      pc_e;
  logic [31:0]      imm_e;
  logic             compressed_e;
  logic             use_imm_e;
  logic             use_pc_e;
  logic             alu_e;
  isa_pkg::alu_op_e alu_op_e;
  logic             br_e;
  isa_pkg::br_op_e  br_op_e;
  logic             br_taken_e;
  logic             lsu_e;
  isa_pkg::lsu_op_e lsu_op_e;
  logic [4:0]       rd_addr_e;
  logic             rd_en_e;
  logic             illegal_e;
  logic             stall;
  logic             br_mispredict;
  logic             should_br;
  logic [31:0]      redirect_pc;
  logic             rd_en_w;
  logic [4:0]       rd_addr_w;
  logic [31:0]      rd_data_w;
  logic             wb_cyc;
  logic             wb_stb;
  logic             wb_we;
  logic [31:2]      wb_adr;
  logic [3:0]       wb_sel;
  logic [31:0]      wb_dat_w;
  logic [31:0]      wb_dat_r;
  logic             wb_ack;
  logic [95:0]      test_name;  // Expected values travel with the instruction to the checker
  logic [31:0]      exp_wb;
  logic [31:0]      exp_pc;
  logic             exp_sb;
  logic             exp_mp;
  entry_t           tbl [NumTests];
  logic [31:0]      mem [64];
  logic [31:0]      lfsr_state;
  int               wait_left;
  logic             in_cycle;

  exec_mem_top DUT (.*);
  exec_mem_checker chk (.*);

  always #10 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic take_bit(output logic b);
    b          = lfsr_state[0];
    lfsr_state = lfsr_next(lfsr_state);
  endtask

  function automatic entry_t alu_entry(input logic [95:0] name, input isa_pkg::alu_op_e op,
                                       input logic [31:0] a, input logic [31:0] b,
                                       input logic use_imm, input logic [31:0] exp);
    entry_t e;
    e         = '0;
    e.name    = name;
    e.alu     = 1'b1;
    e.alu_op  = op;
    e.rs1     = a;
    e.rs2     = use_imm ? 32'h0 : b;
    e.imm     = use_imm ? b : 32'h0;
    e.use_imm = use_imm;
    e.rd_en   = 1'b1;
    e.exp_wb  = exp;
    return e;
  endfunction

  function automatic entry_t br_entry(input logic [95:0] name, input isa_pkg::br_op_e op,
                                      input logic [31:0] a, input logic [31:0] b,
                                      input logic taken, input logic compressed,
                                      input logic [31:0] pc, input logic sb, input logic mp,
                                      input logic [31:0] target);
    entry_t e;
    e            = '0;
    e.name       = name;
    e.br         = 1'b1;
    e.br_op      = op;
    e.rs1        = a;
    e.rs2        = b;
    e.taken      = taken;
    e.compressed = compressed;
    e.pc         = pc;
    e.imm        = 32'h40;  // Branch offset, the target is pc + 0x40
    e.use_pc     = 1'b1;
    e.use_imm    = 1'b1;
    e.exp_sb     = sb;
    e.exp_mp     = mp;
    e.exp_pc     = target;
    return e;
  endfunction

  function automatic entry_t mem_entry(input logic [95:0] name, input isa_pkg::lsu_op_e op,
                                       input logic [31:0] ofs, input logic [31:0] data,
                                       input logic rd_en, input logic [31:0] exp);
    entry_t e;
    e         = '0;
    e.name    = name;
    e.lsu     = 1'b1;
    e.lsu_op  = op;
    e.rs1     = 32'h40;  // All accesses hit memory word 16
    e.imm     = ofs;
    e.use_imm = 1'b1;
    e.rs2     = data;
    e.rd_en   = rd_en;
    e.exp_wb  = exp;
    return e;
  endfunction

  task automatic set_inputs(input entry_t t);
    rs1_data_e   = t.rs1;
    rs2_data_e   = t.rs2;
    pc_e         = t.pc[31:1];
    imm_e        = t.imm;
    compressed_e = t.compressed;
    use_imm_e    = t.use_imm;
    use_pc_e     = t.use_pc;
    alu_e        = t.alu;
    alu_op_e     = t.alu_op;
    br_e         = t.br;
    br_op_e      = t.br_op;
    br_taken_e   = t.taken;
    lsu_e        = t.lsu;
    lsu_op_e     = t.lsu_op;
    rd_addr_e    = t.rd;
    rd_en_e      = t.rd_en;
    illegal_e    = t.illegal;
    test_name    = t.name;
    exp_wb       = t.exp_wb;
    exp_pc       = t.exp_pc;
    exp_sb       = t.exp_sb;
    exp_mp       = t.exp_mp;
  endtask

  // Presents one instruction and returns just after the edge that accepts it
  task automatic drive(input entry_t t);
    set_inputs(t);
    valid_e = 1'b1;
    while (stall) begin
      @(posedge clk);
      #2;
    end
    @(posedge clk);
    #2;
  endtask

  task automatic print_counts();
    $display("Checks finished with %0d value errors and %0d other errors",
             chk.value_errors, chk.other_errors);
  endtask

  // Wishbone slave with 0 to 3 wait states per cycle
  always @(posedge clk) begin
    logic b0;
    logic b1;
    #2;
    if (wb_ack) begin
      wb_ack = 1'b0;
    end else if (wb_cyc && wb_stb) begin
      if (!in_cycle) begin
        take_bit(b0);
        take_bit(b1);
        wait_left = {b1, b0};
        in_cycle  = 1'b1;
      end
      if (wait_left == 0) begin
        in_cycle = 1'b0;
        wb_ack   = 1'b1;
        if (wb_we) begin
          for (int i = 0; i < 4; i++) begin
            if (wb_sel[i]) mem[wb_adr[7:2]][8*i +: 8] = wb_dat_w[8*i +: 8];
          end
        end else begin
          wb_dat_r = mem[wb_adr[7:2]];
        end
      end else begin
        wait_left--;
      end
    end
  end

  initial begin
    repeat (NumTests * 8 + 100) @(posedge clk);
    $display("Timeout: the table did not finish within %0d cycles", NumTests * 8 + 100);
    print_counts();
    $display("=== FAIL ===");
    $finish;
  end

  initial begin
    clk        = 1'b0;
    rst_n      = 1'b0;
    valid_e    = 1'b0;
    wb_dat_r   = '0;
    wb_ack     = 1'b0;
    lfsr_state = 32'h8b68_12cb;
    in_cycle   = 1'b0;
    wait_left  = 0;
    set_inputs('0);
    for (int i = 0; i < 64; i++) mem[i] = 32'h5A5A_0000 ^ (32'(i) * 32'h0101_0101);
    tbl[0]  = alu_entry("add_rr", alu_add, 32'h0000_1234, 32'h0000_0F00, 1'b0, 32'h0000_2134);
    tbl[1]  = alu_entry("sub_rr", alu_sub, 32'd5, 32'd7, 1'b0, 32'hFFFF_FFFE);
    tbl[2]  = alu_entry("sll_ri", alu_sll, 32'd3, 32'h24, 1'b1, 32'h0000_0030);
    tbl[3]  = alu_entry("slt_rr", alu_slt, 32'hFFFF_FFF0, 32'd1, 1'b0, 32'd1);
    tbl[4]  = alu_entry("sltu_rr", alu_sltu, 32'hFFFF_FFF0, 32'd1, 1'b0, 32'd0);
    tbl[5]  = alu_entry("xor_ri", alu_xor, 32'hF0F0_F0F0, 32'h0FFF, 1'b1, 32'hF0F0_FF0F);
    tbl[6]  = alu_entry("srl_rr", alu_srl, 32'h8000_0000, 32'd4, 1'b0, 32'h0800_0000);
    tbl[7]  = alu_entry("sra_rr", alu_sra, 32'h8000_0000, 32'd4, 1'b0, 32'hF800_0000);
    tbl[8]  = alu_entry("or_ri", alu_or, 32'h0000_00F0, 32'h0F, 1'b1, 32'h0000_00FF);
    tbl[9]  = alu_entry("and_rr", alu_and, 32'h1234_5678, 32'h0F0F_0F0F, 1'b0, 32'h0204_0608);
    tbl[10] = alu_entry("lui", alu_passb, 32'h0, 32'hABCD_E000, 1'b1, 32'hABCD_E000);
    tbl[11] = alu_entry("auipc", alu_add, 32'h0, 32'h0000_2000, 1'b1, 32'h0000_3000);
    tbl[11].use_pc = 1'b1;
    tbl[11].pc     = 32'h0000_1000;
    tbl[12] = br_entry("beq_t_np", br_beq, 32'd5, 32'd5, 1'b0, 1'b0, 32'h100, 1, 0, 32'h140);
    tbl[13] = br_entry("bne_t_p", br_bne, 32'd1, 32'd2, 1'b1, 1'b0, 32'h180, 0, 0, 32'h0);
    tbl[14] = br_entry("blt_nt_p", br_blt, 32'd5, 32'hFFFF_FFFF, 1'b1, 1'b0, 32'h200, 0, 1, 32'h204);
    tbl[15] = br_entry("bge_nt_pc", br_bge, 32'hFFFF_FFFE, 32'd3, 1'b1, 1'b1, 32'h300, 0, 1, 32'h302);
    tbl[16] = br_entry("bltu_nt_np", br_bltu, 32'hFFFF_FFFF, 32'd1, 1'b0, 1'b0, 32'h380, 0, 0, 32'h0);
    tbl[17] = br_entry("bgeu_t_np", br_bgeu, 32'hFFFF_FFFF, 32'd1, 1'b0, 1'b0, 32'h400, 1, 0, 32'h440);
    tbl[18] = mem_entry("sw", lsu_sw, 32'd0, 32'h8765_4321, 1'b0, 32'h0);
    tbl[19] = mem_entry("sb_off1", lsu_sb, 32'd1, 32'h0000_00A5, 1'b0, 32'h0);
    tbl[20] = mem_entry("sh_off2", lsu_sh, 32'd2, 32'h0000_F00D, 1'b0, 32'h0);
    tbl[21] = mem_entry("lb_off1", lsu_lb, 32'd1, 32'h0, 1'b1, 32'hFFFF_FFA5);
    tbl[22] = mem_entry("lbu_off1", lsu_lbu, 32'd1, 32'h0, 1'b1, 32'h0000_00A5);
    tbl[23] = mem_entry("lh_off2", lsu_lh, 32'd2, 32'h0, 1'b1, 32'hFFFF_F00D);
    tbl[24] = mem_entry("lhu_off2", lsu_lhu, 32'd2, 32'h0, 1'b1, 32'h0000_F00D);
    tbl[25] = mem_entry("lw", lsu_lw, 32'd0, 32'h0, 1'b1, 32'hF00D_A521);
    tbl[26] = alu_entry("illegal", alu_add, 32'd1, 32'd2, 1'b0, 32'd3);
    tbl[26].illegal = 1'b1;
    tbl[27] = alu_entry("no_rd_en", alu_add, 32'd1, 32'd2, 1'b0, 32'd3);
    tbl[27].rd_en = 1'b0;
    tbl[28] = alu_entry("add_after", alu_add, 32'd1, 32'd1, 1'b0, 32'd2);
    for (int i = 0; i < NumTests; i++) tbl[i].rd = 5'(i % 31 + 1);
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
    @(posedge clk);
    #2;
    for (int i = 0; i < NumTests; i++) drive(tbl[i]);
    valid_e = 1'b0;
    while (chk.pending() != 0 || stall) @(posedge clk);
    repeat (4) @(posedge clk);  // Room for any stray writeback to show up
    print_counts();
    if (chk.value_errors + chk.other_errors == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule : tb_exec_mem

`default_nettype wire

//--- src.f
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/ex_mem_if.sv
rtl/exu_alu.sv
rtl/exu_bru.sv
rtl/exu.sv
rtl/lsu.sv
rtl/exec_mem_top.sv
bench/exec_mem_checker.sv
bench/tb_exec_mem.sv
